// File: rtl/sdp_wdma_cfg_pkg.sv
// ========================================
// static register fields seen by the wdma
// done-interrupt and stall statistic logic
// ========================================
package sdp_wdma_cfg_pkg;

  // element-wise alu algorithm field
  typedef enum logic [1:0] {
    ALGO_MAX = 2'd0,
    ALGO_MIN = 2'd1,
    ALGO_SUM = 2'd2,
    // equal mode, no memory write follows
    ALGO_EQL = 2'd3
  } ew_alu_algo_e;

  // output destination of the datapath
  typedef enum logic [0:0] {
    DST_MEM = 1'b0,
    // straight to pooling engine
    DST_PDP = 1'b1
  } output_dst_e;

  // register group fields, static while a layer is pending
  typedef struct packed {
    logic         ew_bypass;
    logic         ew_alu_bypass;
    ew_alu_algo_e ew_alu_algo;
    output_dst_e  output_dst;
    // operation enable
    logic         op_en;
    // dma perf counting enable
    logic         perf_dma_en;
  } wdma_cfg_t;

endpackage

// File: rtl/sdp_wdma_if_pkg.sv
// ========================================
// datapath and dma side types
// ========================================
package sdp_wdma_if_pkg;

  // selects ping-pong register group 0 or 1
  typedef logic [0:0] layer_ptr_t;

  // one pulse bit per register group
  typedef logic [1:0] done_intr_t;

  // stall performance counter value
  typedef logic [31:0] stall_cnt_t;

  // interrupt request from datapath, one strobe per finished layer
  typedef struct packed {
    logic       pvld;
    layer_ptr_t ptr;
  } intr_req_t;

  // dma engine write status strobes
  typedef struct packed {
    logic req_vld;
    logic req_rdy;
    // last write of a layer done, in request order
    logic rsp_complete;
  } dma_wr_status_t;

endpackage

// File: rtl/sdp_wdma_intr_queue.sv
module sdp_wdma_intr_queue import sdp_wdma_if_pkg::*; #(
  parameter int INTR_QUEUE_DEPTH = 4
) (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       push_i,
  input  layer_ptr_t push_ptr_i,
  input  logic       pop_i,
  output layer_ptr_t head_o
);

  localparam int IDX_W = $clog2(INTR_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(INTR_QUEUE_DEPTH + 1);

  // pointer storage, payload only
  layer_ptr_t       ptr_mem [INTR_QUEUE_DEPTH];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [CNT_W-1:0] occ_cnt;
  logic             empty;
  logic             full;

  // circular increment, depth need not be a power of two
  function automatic logic [IDX_W-1:0] idx_inc(input logic [IDX_W-1:0] idx);
    if (idx == IDX_W'(INTR_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return idx + IDX_W'(1);
  endfunction

  assign empty = (occ_cnt == '0);
  assign full  = (occ_cnt == CNT_W'(INTR_QUEUE_DEPTH));

  // ========================================
  // write side
  // ========================================
  always_ff @(posedge nvdla_core_clk) begin
    if (push_i) begin
      ptr_mem[wr_idx] <= push_ptr_i;
    end
  end

  // indices and occupancy
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_idx  <= '0;
      rd_idx  <= '0;
      occ_cnt <= '0;
    end else begin
      if (push_i) begin
        wr_idx <= idx_inc(wr_idx);
      end
      if (pop_i) begin
        rd_idx <= idx_inc(rd_idx);
      end
      // push and pop together leave the count alone
      case ({push_i, pop_i})
        2'b10:   occ_cnt <= occ_cnt + CNT_W'(1);
        2'b01:   occ_cnt <= occ_cnt - CNT_W'(1);
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

  // ========================================
  // read side
  // ========================================
  // oldest pointer, valid while not empty
  assign head_o = ptr_mem[rd_idx];

  // completion must find its layer already queued
  a_no_pop_empty: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(pop_i && empty)
  ) else $error("write completion with no pending layer");

  // more finished layers than the queue can hold
  a_no_push_full: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(push_i && full && !pop_i)
  ) else $error("layer pointer pushed into full queue");

endmodule

// File: rtl/sdp_wdma_done_intr.sv
module sdp_wdma_done_intr import sdp_wdma_cfg_pkg::*, sdp_wdma_if_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  wdma_cfg_t  cfg_i,
  input  intr_req_t  intr_req_i,
  input  logic       wr_complete_i,
  input  layer_ptr_t queue_head_i,
  output logic       queue_push_o,
  output layer_ptr_t queue_push_ptr_o,
  output done_intr_t done_intr_o
);

  logic       cfg_mode_eql;
  logic       cfg_mode_pdp;
  logic       cfg_mode_quiet;
  // pulses raised straight from the request
  done_intr_t intr_internal;
  // pulses raised from a write completion
  done_intr_t intr_wr;
  done_intr_t done_intr_q;

  // ========================================
  // quiet mode decode
  // ========================================
  // element-wise equal, result goes nowhere in memory
  assign cfg_mode_eql = (cfg_i.ew_bypass == 1'b0)
                      & (cfg_i.ew_alu_bypass == 1'b0)
                      & (cfg_i.ew_alu_algo == ALGO_EQL);
  // pooling engine takes the output directly
  assign cfg_mode_pdp = (cfg_i.output_dst == DST_PDP);
  assign cfg_mode_quiet = cfg_mode_eql | cfg_mode_pdp;

  // ========================================
  // request routing
  // ========================================
  // normal mode waits for the last write
  assign queue_push_o     = intr_req_i.pvld & ~cfg_mode_quiet;
  assign queue_push_ptr_o = intr_req_i.ptr;

  // per register group pulse sources
  always_comb begin
    for (int i = 0; i < $bits(done_intr_t); i++) begin
      intr_internal[i] = cfg_mode_quiet & intr_req_i.pvld
                       & (intr_req_i.ptr == layer_ptr_t'(i));
      // head names the layer this completion retires
      intr_wr[i] = wr_complete_i & (queue_head_i == layer_ptr_t'(i));
    end
  end

  // ========================================
  // registered done pulses
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_intr_q <= '0;
    end else begin
      done_intr_q <= intr_wr | intr_internal;
    end
  end

  assign done_intr_o = done_intr_q;

  // a queued layer and a quiet layer on one group would merge into one pulse
  a_no_intr_overlap: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (intr_wr & intr_internal) == '0
  ) else $error("write and quiet done interrupt hit the same group");

endmodule

// File: rtl/sdp_wdma_stall_cnt.sv
module sdp_wdma_stall_cnt import sdp_wdma_cfg_pkg::*, sdp_wdma_if_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  wdma_cfg_t  cfg_i,
  input  logic       dma_wr_req_vld_i,
  input  logic       dma_wr_req_rdy_i,
  input  logic       op_load_i,
  output stall_cnt_t stall_cnt_o
);

  logic       stall_cnt_cen;
  logic       stall_cnt_inc;
  logic       stall_cnt_clr;
  stall_cnt_t stall_cnt_nxt;
  stall_cnt_t stall_cnt_q;

  // ========================================
  // perf statistic control
  // ========================================
  // count only with op and perf both on
  assign stall_cnt_cen = cfg_i.op_en & cfg_i.perf_dma_en;
  // request offered but dma not ready
  assign stall_cnt_inc = dma_wr_req_vld_i & ~dma_wr_req_rdy_i;
  // new operation restarts the statistic
  assign stall_cnt_clr = op_load_i;

  // clear wins over increment, wraps at 32 bits
  always_comb begin
    if (stall_cnt_clr) begin
      stall_cnt_nxt = '0;
    end else if (stall_cnt_inc) begin
      stall_cnt_nxt = stall_cnt_q + stall_cnt_t'(1);
    end else begin
      stall_cnt_nxt = stall_cnt_q;
    end
  end

  // disabled counter holds, op_load ignored too
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt_q <= '0;
    end else if (stall_cnt_cen) begin
      stall_cnt_q <= stall_cnt_nxt;
    end
  end

  // register read straight out
  assign stall_cnt_o = stall_cnt_q;

endmodule

// File: rtl/sdp_wdma_intr.sv
module sdp_wdma_intr import sdp_wdma_cfg_pkg::*, sdp_wdma_if_pkg::*; #(
  parameter int INTR_QUEUE_DEPTH = 4
) (
  input  logic           nvdla_core_clk,
  input  logic           nvdla_core_rstn,
  input  wdma_cfg_t      cfg_i,
  input  intr_req_t      intr_req_i,
  input  dma_wr_status_t dma_wr_i,
  input  logic           op_load_i,
  output done_intr_t     done_intr_o,
  output stall_cnt_t     wdma_stall_o
);

  // done_intr to queue
  logic       queue_push;
  layer_ptr_t queue_push_ptr;
  // queue head back to done_intr
  layer_ptr_t queue_head;

  // ========================================
  // done interrupt
  // ========================================
  sdp_wdma_done_intr u_done_intr (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .cfg_i            (cfg_i),
    .intr_req_i       (intr_req_i),
    .wr_complete_i    (dma_wr_i.rsp_complete),
    .queue_head_i     (queue_head),
    .queue_push_o     (queue_push),
    .queue_push_ptr_o (queue_push_ptr),
    .done_intr_o      (done_intr_o)
  );

  // completion retires the oldest pending layer
  sdp_wdma_intr_queue #(
    .INTR_QUEUE_DEPTH (INTR_QUEUE_DEPTH)
  ) u_intr_queue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .push_i          (queue_push),
    .push_ptr_i      (queue_push_ptr),
    .pop_i           (dma_wr_i.rsp_complete),
    .head_o          (queue_head)
  );

  // ========================================
  // perf statistic
  // ========================================
  sdp_wdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .cfg_i            (cfg_i),
    .dma_wr_req_vld_i (dma_wr_i.req_vld),
    .dma_wr_req_rdy_i (dma_wr_i.req_rdy),
    .op_load_i        (op_load_i),
    .stall_cnt_o      (wdma_stall_o)
  );

endmodule

// File: testbench/tb_sdp_wdma_intr.sv
module tb_sdp_wdma_intr import sdp_wdma_cfg_pkg::*, sdp_wdma_if_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int QUEUE_DEPTH = 4;
  localparam int NUM_RANDOM  = 64;

  // one stimulus row, applied on a falling edge
  typedef struct packed {
    wdma_cfg_t      cfg;
    intr_req_t      req;
    dma_wr_status_t dma;
    logic           op_load;
  } stim_row_t;

  // field order ew_bypass, ew_alu_bypass, algo, dst, op_en, perf_dma_en
  localparam wdma_cfg_t CFG_MEM    = '{1'b1, 1'b1, ALGO_MAX, DST_MEM, 1'b1, 1'b1};
  localparam wdma_cfg_t CFG_EQL    = '{1'b0, 1'b0, ALGO_EQL, DST_MEM, 1'b1, 1'b1};
  localparam wdma_cfg_t CFG_PDP    = '{1'b1, 1'b1, ALGO_SUM, DST_PDP, 1'b1, 1'b1};
  localparam wdma_cfg_t CFG_NOPERF = '{1'b1, 1'b1, ALGO_MAX, DST_MEM, 1'b1, 1'b0};
  localparam wdma_cfg_t CFG_OFF    = '{1'b1, 1'b1, ALGO_MAX, DST_MEM, 1'b0, 1'b1};
  // near the equal mode, each one field away, all still writing memory
  localparam wdma_cfg_t CFG_ALU_SUM = '{1'b0, 1'b0, ALGO_SUM, DST_MEM, 1'b1, 1'b1};
  localparam wdma_cfg_t CFG_EW_BYP  = '{1'b1, 1'b0, ALGO_EQL, DST_MEM, 1'b1, 1'b1};
  localparam wdma_cfg_t CFG_ALU_BYP = '{1'b0, 1'b1, ALGO_EQL, DST_MEM, 1'b1, 1'b1};

  logic           nvdla_core_clk;
  logic           nvdla_core_rstn;
  wdma_cfg_t      cfg;
  intr_req_t      intr_req;
  dma_wr_status_t dma_wr;
  logic           op_load;
  done_intr_t     done_intr;
  stall_cnt_t     wdma_stall;

  stim_row_t  rows [$];
  logic       table_ready = 1'b0;
  integer     seed;
  int         cur_row;
  // reference model state
  layer_ptr_t ref_queue [$];
  done_intr_t exp_done;
  stall_cnt_t exp_stall;

  sdp_wdma_intr #(
    .INTR_QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_dut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_i           (cfg),
    .intr_req_i      (intr_req),
    .dma_wr_i        (dma_wr),
    .op_load_i       (op_load),
    .done_intr_o     (done_intr),
    .wdma_stall_o    (wdma_stall)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // flags {pvld, ptr}_{req_vld, req_rdy, rsp_complete}_{op_load}
  function automatic stim_row_t make_row(input wdma_cfg_t row_cfg, input logic [5:0] flags);
    stim_row_t row;
    row.cfg = row_cfg;
    {row.req, row.dma, row.op_load} = flags;
    return row;
  endfunction

  // ========================================
  // stimulus table
  // ========================================
  task automatic build_table();
    integer r;
    int     pending;
    logic   push;
    logic   pop;
    pending = 0;
    // memory mode, three layers then their completions
    rows.push_back(make_row(CFG_MEM, 6'b10_000_0));
    rows.push_back(make_row(CFG_MEM, 6'b11_000_0));
    rows.push_back(make_row(CFG_MEM, 6'b10_000_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_000_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_001_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_001_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_000_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_001_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_000_0));
    // equal mode needs all three fields, otherwise the layer queues
    rows.push_back(make_row(CFG_ALU_SUM, 6'b10_000_0));
    rows.push_back(make_row(CFG_ALU_SUM, 6'b00_001_0));
    rows.push_back(make_row(CFG_EW_BYP, 6'b11_000_0));
    rows.push_back(make_row(CFG_EW_BYP, 6'b00_001_0));
    rows.push_back(make_row(CFG_ALU_BYP, 6'b10_000_0));
    rows.push_back(make_row(CFG_ALU_BYP, 6'b00_001_0));
    // quiet modes pulse straight from the request
    rows.push_back(make_row(CFG_EQL, 6'b11_000_0));
    rows.push_back(make_row(CFG_EQL, 6'b10_000_0));
    rows.push_back(make_row(CFG_EQL, 6'b00_000_0));
    rows.push_back(make_row(CFG_PDP, 6'b11_000_0));
    rows.push_back(make_row(CFG_PDP, 6'b00_000_0));
    // stall counting, enables and clear
    rows.push_back(make_row(CFG_MEM, 6'b00_000_1));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_110_0));
    rows.push_back(make_row(CFG_NOPERF, 6'b00_100_0));
    rows.push_back(make_row(CFG_NOPERF, 6'b00_100_1));
    rows.push_back(make_row(CFG_OFF, 6'b00_100_1));
    rows.push_back(make_row(CFG_OFF, 6'b00_100_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_0));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_1));
    rows.push_back(make_row(CFG_MEM, 6'b00_100_0));
    // random memory mode mix
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      push = r[0];
      pop = r[1] & r[2];
      // completions only for layers queued in an earlier row
      if (pending == 0) begin
        pop = 1'b0;
      end
      if (pending == QUEUE_DEPTH && !pop) begin
        push = 1'b0;
      end
      rows.push_back(make_row(CFG_MEM, {push, r[3], r[4], r[5], pop, (r[9:6] == 4'd0)}));
      pending = pending + int'(push) - int'(pop);
    end
    // drain whatever is still waiting
    while (pending > 0) begin
      rows.push_back(make_row(CFG_MEM, 6'b00_001_0));
      pending--;
    end
    rows.push_back(make_row(CFG_MEM, 6'b00_000_0));
  endtask

  task automatic drive_row(input stim_row_t row);
    cfg      = row.cfg;
    intr_req = row.req;
    dma_wr   = row.dma;
    op_load  = row.op_load;
  endtask

  // ========================================
  // reference model
  // ========================================
  task automatic apply_model(input stim_row_t row);
    done_intr_t nxt_done;
    logic       quiet;
    quiet = (!row.cfg.ew_bypass && !row.cfg.ew_alu_bypass && row.cfg.ew_alu_algo == ALGO_EQL)
          || (row.cfg.output_dst == DST_PDP);
    nxt_done = '0;
    // completion retires the oldest layer
    if (row.dma.rsp_complete) begin
      nxt_done[ref_queue[0]] = 1'b1;
      void'(ref_queue.pop_front());
    end
    if (row.req.pvld) begin
      if (quiet) begin
        nxt_done[row.req.ptr] = 1'b1;
      end else begin
        ref_queue.push_back(row.req.ptr);
      end
    end
    exp_done = nxt_done;
    // disabled counter ignores op_load too
    if (row.cfg.op_en && row.cfg.perf_dma_en) begin
      if (row.op_load) begin
        exp_stall = '0;
      end else if (row.dma.req_vld && !row.dma.req_rdy) begin
        exp_stall = exp_stall + stall_cnt_t'(1);
      end
    end
  endtask

  task automatic check_done_intr(input done_intr_t actual, input done_intr_t expected);
    if (actual !== expected) begin
      $display("MISMATCH done_intr_o: got 0x%h expected 0x%h after row %0d",
               actual, expected, cur_row);
      $display("Test FAILED");
      $fatal(1, "done_intr_o compare");
    end
  endtask

  task automatic check_stall(input stall_cnt_t actual, input stall_cnt_t expected);
    if (actual !== expected) begin
      $display("MISMATCH wdma_stall_o: got 0x%h expected 0x%h after row %0d",
               actual, expected, cur_row);
      $display("Test FAILED");
      $fatal(1, "wdma_stall_o compare");
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    seed = 12457;
    nvdla_core_rstn = 1'b0;
    drive_row(make_row(CFG_MEM, 6'b00_000_0));
    exp_done = '0;
    exp_stall = '0;
    cur_row = -1;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    // each check looks at the row driven one edge earlier
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge nvdla_core_clk);
      check_done_intr(done_intr, exp_done);
      check_stall(wdma_stall, exp_stall);
      cur_row = i;
      drive_row(rows[i]);
      apply_model(rows[i]);
    end
    @(negedge nvdla_core_clk);
    check_done_intr(done_intr, exp_done);
    check_stall(wdma_stall, exp_stall);
    $display("Test OK");
    $finish;
  end

  // watchdog, sized from the table length
  initial begin
    wait (table_ready);
    #((rows.size() + 50) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", rows.size() + 50);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: project.f
rtl/sdp_wdma_cfg_pkg.sv
rtl/sdp_wdma_if_pkg.sv
rtl/sdp_wdma_intr_queue.sv
rtl/sdp_wdma_done_intr.sv
rtl/sdp_wdma_stall_cnt.sv
rtl/sdp_wdma_intr.sv
testbench/tb_sdp_wdma_intr.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_sdp_wdma_intr
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_BIN   ?= sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	-./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
